//--- common/ldpc_pkg.sv
package ldpc_pkg;

	// message and block sizes
	localparam int QUAN_SIZE         = 4; // bits per message
	localparam int CN_DEGREE         = 4; // submatrix columns per row
	localparam int CHECK_PARALLELISM = 2; // lanes per row chunk
	localparam int LAYER_NUM         = 3;
	localparam int ROW_CHUNK_NUM     = 2;
	localparam int CH_BUFF_DEPTH     = LAYER_NUM * ROW_CHUNK_NUM;
	localparam int ADDR_W            = $clog2(CH_BUFF_DEPTH);
	localparam int MSG_MAX           = 7; // saturation magnitude
	localparam int PIPE_LATENCY      = 3; // ram read, cnu, vnu

	// one signed message
	typedef logic signed [QUAN_SIZE-1:0] msg_t;

	// all lanes of one column
	typedef msg_t [CHECK_PARALLELISM-1:0] lane_msgs_t;

	// one row chunk, indexed [column][lane]
	typedef lane_msgs_t [CN_DEGREE-1:0] row_msgs_t;

	// hard decision bits, indexed [column][lane]
	typedef logic [CN_DEGREE-1:0][CHECK_PARALLELISM-1:0] hd_t;

	// follows a row chunk down the pipeline
	typedef struct packed {
		logic              valid;
		logic              last; // final chunk of the run
		logic [ADDR_W-1:0] addr;
	} row_tag_t;

	// host side buffer load
	typedef struct packed {
		logic              we_ch;  // write channel buffer
		logic              we_c2v; // write prior c2v buffer
		logic [ADDR_W-1:0] addr;
		row_msgs_t         ch;
		row_msgs_t         c2v;
	} ch_write_t;

	// one decoded row chunk
	typedef struct packed {
		row_tag_t  tag;
		row_msgs_t v2c; // extrinsic v2c
		row_msgs_t c2v; // newly updated c2v
		hd_t       hd;
	} row_result_t;

endpackage

//--- rtl/ch_msg_ram.sv
`timescale 1ns/10ps

module ch_msg_ram #(
	parameter type payload_t = ldpc_pkg::row_msgs_t
) (
	input  logic                        read_clk,
	input  logic                        we,
	input  logic [ldpc_pkg::ADDR_W-1:0] waddr,
	input  payload_t                    din,
	input  logic                        rd_en,
	input  logic [ldpc_pkg::ADDR_W-1:0] raddr,
	output payload_t                    dout
);

	payload_t mem [ldpc_pkg::CH_BUFF_DEPTH]; // one entry per row chunk

	always_ff @(posedge read_clk) begin
		if (we) begin
			mem[waddr] <= din;
		end
	end

	// registered read, dout holds between reads
	always_ff @(posedge read_clk) begin
		if (rd_en) begin
			dout <= mem[raddr];
		end
	end

endmodule

//--- rtl/chunk_counter.sv
`timescale 1ns/10ps

module chunk_counter (
	input  logic                        read_clk,
	input  logic                        arst_n,
	input  logic                        rd_en,
	output logic [ldpc_pkg::ADDR_W-1:0] rd_addr,
	output logic                        last_addr
);

	localparam logic [ldpc_pkg::ADDR_W-1:0] LAST = ldpc_pkg::ADDR_W'(ldpc_pkg::CH_BUFF_DEPTH - 1);

	logic [ldpc_pkg::ADDR_W-1:0] count;

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (rd_en) begin
			if (last_addr) begin
				count <= '0; // wrap so the next run starts at row chunk 0
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	assign rd_addr   = count;
	assign last_addr = (count == LAST);

endmodule

//--- rtl/decode_ctrl.sv
`timescale 1ns/10ps

module decode_ctrl (
	input  logic               read_clk,
	input  logic               arst_n,
	input  logic               start,
	input  logic               last_addr,
	input  ldpc_pkg::row_tag_t out_tag,
	output logic               rd_en,
	output logic               busy,
	output logic               done
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,   // issuing row chunk addresses
		DRAIN  // waiting for the last result
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = RUN;
				end
			end
			RUN: begin
				if (rd_en && last_addr) begin // last address goes out this cycle
					state_nxt = DRAIN;
				end
			end
			DRAIN: begin
				if (done) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			rd_en <= 1'b0;
		end else begin
			state <= state_nxt;
			rd_en <= (state == RUN) && (state_nxt == RUN); // one cycle after entering RUN
		end
	end

	assign busy = (state != IDLE);
	assign done = (state == DRAIN) && out_tag.valid && out_tag.last;

endmodule

//--- pe/cnu_min_sum.sv
`timescale 1ns/10ps

module cnu_min_sum (
	input  logic                read_clk,
	input  logic                arst_n,
	input  ldpc_pkg::row_tag_t  tag_in,
	input  ldpc_pkg::row_msgs_t v2c_in,
	input  ldpc_pkg::row_msgs_t ch_in,
	input  ldpc_pkg::row_msgs_t c2v_old_in,
	output ldpc_pkg::row_tag_t  tag_out,
	output ldpc_pkg::row_msgs_t c2v_out,
	output ldpc_pkg::row_msgs_t ch_out,
	output ldpc_pkg::row_msgs_t c2v_old_out
);

	localparam int MAG_W = ldpc_pkg::QUAN_SIZE - 1;
	localparam int IDX_W = $clog2(ldpc_pkg::CN_DEGREE);

	ldpc_pkg::row_msgs_t c2v_nxt;

	// -8 has no positive twin and is read as 7
	function automatic logic [MAG_W-1:0] msg_mag(input ldpc_pkg::msg_t m);
		ldpc_pkg::msg_t a;
		a = (m < 0) ? -m : m;
		return (a < 0) ? MAG_W'(ldpc_pkg::MSG_MAX) : a[MAG_W-1:0];
	endfunction

	always_comb begin
		logic [MAG_W-1:0]              mag [ldpc_pkg::CN_DEGREE];
		logic [ldpc_pkg::CN_DEGREE-1:0] neg;
		logic [MAG_W-1:0]              min1;
		logic [MAG_W-1:0]              min2;
		logic [MAG_W-1:0]              om;
		logic [IDX_W-1:0]              idx;
		logic                          sgn_all;
		c2v_nxt = '0;
		for (int l = 0; l < ldpc_pkg::CHECK_PARALLELISM; l++) begin
			min1    = MAG_W'(ldpc_pkg::MSG_MAX);
			min2    = MAG_W'(ldpc_pkg::MSG_MAX);
			idx     = '0;
			sgn_all = 1'b0;
			for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
				mag[c]  = msg_mag(v2c_in[c][l]);
				neg[c]  = v2c_in[c][l][ldpc_pkg::QUAN_SIZE-1]; // zero counts as positive
				sgn_all = sgn_all ^ neg[c];
				if (mag[c] < min1) begin
					min2 = min1;
					min1 = mag[c];
					idx  = IDX_W'(c);
				end else if (mag[c] < min2) begin
					min2 = mag[c];
				end
			end
			// exclude each column's own contribution
			for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
				om = (idx == IDX_W'(c)) ? min2 : min1;
				if (sgn_all ^ neg[c]) begin
					c2v_nxt[c][l] = -ldpc_pkg::msg_t'({1'b0, om});
				end else begin
					c2v_nxt[c][l] = ldpc_pkg::msg_t'({1'b0, om});
				end
			end
		end
	end

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			tag_out <= '0;
		end else begin
			tag_out <= tag_in;
		end
	end

	// ch and prior c2v ride along to stay aligned with the new c2v
	always_ff @(posedge read_clk) begin
		c2v_out     <= c2v_nxt;
		ch_out      <= ch_in;
		c2v_old_out <= c2v_old_in;
	end

endmodule

//--- pe/vnu_update.sv
`timescale 1ns/10ps

module vnu_update (
	input  logic                  read_clk,
	input  logic                  arst_n,
	input  ldpc_pkg::row_tag_t    tag_in,
	input  ldpc_pkg::row_msgs_t   ch_in,
	input  ldpc_pkg::row_msgs_t   c2v_new_in,
	input  ldpc_pkg::row_msgs_t   c2v_old_in,
	output ldpc_pkg::row_result_t res
);

	localparam int SUM_W = ldpc_pkg::QUAN_SIZE + 2; // room for three terms

	ldpc_pkg::row_tag_t  tag_q;
	ldpc_pkg::row_msgs_t v2c_nxt;
	ldpc_pkg::row_msgs_t v2c_q;
	ldpc_pkg::row_msgs_t c2v_q;
	ldpc_pkg::hd_t       hd_nxt;
	ldpc_pkg::hd_t       hd_q;

	function automatic ldpc_pkg::msg_t sat_msg(input logic signed [SUM_W-1:0] x);
		if (x > ldpc_pkg::MSG_MAX) begin
			return ldpc_pkg::msg_t'(ldpc_pkg::MSG_MAX);
		end else if (x < -ldpc_pkg::MSG_MAX) begin
			return ldpc_pkg::msg_t'(-ldpc_pkg::MSG_MAX);
		end
		return ldpc_pkg::msg_t'(x);
	endfunction

	always_comb begin
		ldpc_pkg::msg_t         ch;
		ldpc_pkg::msg_t         c2v_new;
		ldpc_pkg::msg_t         c2v_old;
		ldpc_pkg::msg_t         post;
		logic signed [SUM_W-1:0] sum2;
		logic signed [SUM_W-1:0] sum3;
		for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
			for (int l = 0; l < ldpc_pkg::CHECK_PARALLELISM; l++) begin
				ch      = ch_in[c][l];
				c2v_new = c2v_new_in[c][l];
				c2v_old = c2v_old_in[c][l];
				sum2    = ch + c2v_new;           // extrinsic toward the next layer
				sum3    = ch + c2v_new + c2v_old; // full posterior
				post    = sat_msg(sum3);
				v2c_nxt[c][l] = sat_msg(sum2);
				hd_nxt[c][l]  = post[ldpc_pkg::QUAN_SIZE-1];
			end
		end
	end

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			tag_q <= '0;
		end else begin
			tag_q <= tag_in;
		end
	end

	always_ff @(posedge read_clk) begin
		v2c_q <= v2c_nxt;
		c2v_q <= c2v_new_in;
		hd_q  <= hd_nxt;
	end

	assign res = '{tag: tag_q, v2c: v2c_q, c2v: c2v_q, hd: hd_q};

endmodule

//--- rtl/ldpc_row_decoder.sv
`timescale 1ns/10ps

module ldpc_row_decoder (
	input  logic                  read_clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  ldpc_pkg::ch_write_t   wr,
	output logic                  busy,
	output logic                  done,
	output ldpc_pkg::row_result_t res
);

	logic                        rd_en;
	logic                        last_addr;
	logic [ldpc_pkg::ADDR_W-1:0] rd_addr;

	ldpc_pkg::row_tag_t  rd_tag;    // tag of the address being issued
	ldpc_pkg::row_tag_t  fetch_tag; // aligned with ram read data
	ldpc_pkg::row_tag_t  cnu_tag;
	ldpc_pkg::row_msgs_t ch_row;
	ldpc_pkg::row_msgs_t c2v_old_row;
	ldpc_pkg::row_msgs_t cnu_c2v;
	ldpc_pkg::row_msgs_t cnu_ch;
	ldpc_pkg::row_msgs_t cnu_c2v_old;

	decode_ctrl u_decode_ctrl (
		.read_clk  (read_clk),
		.arst_n    (arst_n),
		.start     (start),
		.last_addr (last_addr),
		.out_tag   (res.tag),
		.rd_en     (rd_en),
		.busy      (busy),
		.done      (done)
	);

	chunk_counter u_chunk_counter (
		.read_clk  (read_clk),
		.arst_n    (arst_n),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.last_addr (last_addr)
	);

	assign rd_tag = '{valid: rd_en, last: rd_en & last_addr, addr: rd_addr};

	// tag flop matching the one-cycle ram read
	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			fetch_tag <= '0;
		end else begin
			fetch_tag <= rd_tag;
		end
	end

	// channel messages, also the first-pass v2c
	ch_msg_ram #(
		.payload_t (ldpc_pkg::row_msgs_t)
	) u_ch_ram (
		.read_clk (read_clk),
		.we       (wr.we_ch),
		.waddr    (wr.addr),
		.din      (wr.ch),
		.rd_en    (rd_en),
		.raddr    (rd_addr),
		.dout     (ch_row)
	);

	// c2v left by the other layers
	ch_msg_ram #(
		.payload_t (ldpc_pkg::row_msgs_t)
	) u_c2v_ram (
		.read_clk (read_clk),
		.we       (wr.we_c2v),
		.waddr    (wr.addr),
		.din      (wr.c2v),
		.rd_en    (rd_en),
		.raddr    (rd_addr),
		.dout     (c2v_old_row)
	);

	cnu_min_sum u_cnu (
		.read_clk    (read_clk),
		.arst_n      (arst_n),
		.tag_in      (fetch_tag),
		.v2c_in      (ch_row),
		.ch_in       (ch_row),
		.c2v_old_in  (c2v_old_row),
		.tag_out     (cnu_tag),
		.c2v_out     (cnu_c2v),
		.ch_out      (cnu_ch),
		.c2v_old_out (cnu_c2v_old)
	);

	vnu_update u_vnu (
		.read_clk   (read_clk),
		.arst_n     (arst_n),
		.tag_in     (cnu_tag),
		.ch_in      (cnu_ch),
		.c2v_new_in (cnu_c2v),
		.c2v_old_in (cnu_c2v_old),
		.res        (res)
	);

endmodule

//--- tb/ldpc_checker.sv
`timescale 1ns/10ps

module ldpc_checker (
	input logic                  read_clk,
	input logic                  arst_n,
	input logic                  busy,
	input logic                  done,
	input ldpc_pkg::ch_write_t   wr,
	input ldpc_pkg::row_result_t res
);

	// buffers are only loaded between runs
	write_when_idle: assert property (@(posedge read_clk) disable iff (!arst_n)
		(wr.we_ch || wr.we_c2v) |-> !busy)
		else $error("buffer write while busy");

	done_with_row: assert property (@(posedge read_clk) disable iff (!arst_n)
		done |-> res.tag.valid)
		else $error("done without a valid result row");

	row_inside_run: assert property (@(posedge read_clk) disable iff (!arst_n)
		res.tag.valid |-> busy)
		else $error("valid result row while not busy");

endmodule

bind ldpc_row_decoder ldpc_checker checker_i (
	.read_clk (read_clk),
	.arst_n   (arst_n),
	.busy     (busy),
	.done     (done),
	.wr       (wr),
	.res      (res)
);

//--- tb/ldpc_scoreboard.sv
`timescale 1ns/10ps

module ldpc_scoreboard (
	input  logic                  read_clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic                  busy,
	input  logic                  done,
	input  ldpc_pkg::ch_write_t   wr,
	input  ldpc_pkg::row_result_t res,
	output int                    reset_errs,
	output int                    c2v_errs,
	output int                    vnu_errs,
	output int                    timing_errs,
	output int                    rows_checked
);

	localparam int FIRST_ROW = 1 + 4; // start taken at the next edge, first row 4 cycles later
	localparam int LAST_ROW  = ldpc_pkg::CH_BUFF_DEPTH - 1;

	ldpc_pkg::row_msgs_t ch_model  [ldpc_pkg::CH_BUFF_DEPTH];
	ldpc_pkg::row_msgs_t c2v_model [ldpc_pkg::CH_BUFF_DEPTH];
	logic                started;
	logic                in_run;
	logic                busy_fall_due;
	int                  cycle;
	int                  start_cycle;
	int                  next_addr;

	function automatic int value_of(input ldpc_pkg::msg_t m);
		return int'(m);
	endfunction

	function automatic int clamp_to_max(input int v);
		if (v > ldpc_pkg::MSG_MAX) begin
			return ldpc_pkg::MSG_MAX;
		end
		if (v < -ldpc_pkg::MSG_MAX) begin
			return -ldpc_pkg::MSG_MAX;
		end
		return v;
	endfunction

	// each column gets the smallest magnitude and sign parity of the others
	function automatic ldpc_pkg::row_msgs_t min_sum_row(input ldpc_pkg::row_msgs_t v2c);
		ldpc_pkg::row_msgs_t c2v;
		int                  least;
		int                  negs;
		int                  mag;
		for (int l = 0; l < ldpc_pkg::CHECK_PARALLELISM; l++) begin
			for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
				least = ldpc_pkg::MSG_MAX;
				negs  = 0;
				for (int k = 0; k < ldpc_pkg::CN_DEGREE; k++) begin
					if (k != c) begin
						mag   = value_of(v2c[k][l]);
						negs  = negs + ((mag < 0) ? 1 : 0);
						mag   = (mag < 0) ? -mag : mag;
						mag   = (mag > ldpc_pkg::MSG_MAX) ? ldpc_pkg::MSG_MAX : mag; // -8 reads as 7
						least = (mag < least) ? mag : least;
					end
				end
				c2v[c][l] = ldpc_pkg::msg_t'((negs % 2 == 1) ? -least : least);
			end
		end
		return c2v;
	endfunction

	task automatic check_row(input int a);
		ldpc_pkg::row_msgs_t exp_c2v;
		ldpc_pkg::row_msgs_t exp_v2c;
		ldpc_pkg::hd_t       exp_hd;
		int                  ch;
		int                  fresh;
		exp_c2v = min_sum_row(ch_model[a]); // first pass, v2c is the channel row
		for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
			for (int l = 0; l < ldpc_pkg::CHECK_PARALLELISM; l++) begin
				ch            = value_of(ch_model[a][c][l]);
				fresh         = value_of(exp_c2v[c][l]);
				exp_v2c[c][l] = ldpc_pkg::msg_t'(clamp_to_max(ch + fresh));
				exp_hd[c][l]  = clamp_to_max(ch + fresh + value_of(c2v_model[a][c][l])) < 0;
			end
		end
		if (res.c2v !== exp_c2v) begin
			c2v_errs++;
			$display("** Error res.c2v row %0d: got %h, expected %h", a, res.c2v, exp_c2v);
		end
		if (res.v2c !== exp_v2c) begin
			vnu_errs++;
			$display("** Error res.v2c row %0d: got %h, expected %h", a, res.v2c, exp_v2c);
		end
		if (res.hd !== exp_hd) begin
			vnu_errs++;
			$display("** Error res.hd row %0d: got %h, expected %h", a, res.hd, exp_hd);
		end
	endtask

	// outputs are sampled mid-cycle, well away from the clock edge
	always @(negedge read_clk) begin
		if (!arst_n) begin
			reset_errs    = 0;
			c2v_errs      = 0;
			vnu_errs      = 0;
			timing_errs   = 0;
			rows_checked  = 0;
			started       = 1'b0;
			in_run        = 1'b0;
			busy_fall_due = 1'b0;
			cycle         = 0;
			start_cycle   = 0;
			next_addr     = 0;
		end else begin
			cycle++;
			if (wr.we_ch) begin
				ch_model[wr.addr] = wr.ch;
			end
			if (wr.we_c2v) begin
				c2v_model[wr.addr] = wr.c2v;
			end
			if (busy && (wr.we_ch || wr.we_c2v)) begin
				timing_errs++;
				$display("buffer write seen while the decoder was busy");
			end
			if (!started && (busy || done || res.tag.valid)) begin
				reset_errs++;
				$display("** Error idle outputs: busy %h, done %h, res.tag.valid %h",
					busy, done, res.tag.valid);
			end
			if (busy_fall_due && busy) begin
				timing_errs++;
				$display("busy still high the cycle after done");
			end
			busy_fall_due = 1'b0;
			if (in_run && cycle > start_cycle && !busy) begin
				timing_errs++;
				$display("busy went low before the run ended");
			end
			if (done && !res.tag.valid) begin
				timing_errs++;
				$display("done pulsed without a result row");
			end
			if (res.tag.valid && !in_run) begin
				timing_errs++;
				$display("result row arrived with no decode run in progress");
			end else if (res.tag.valid) begin
				check_row(next_addr);
				rows_checked++;
				if (res.tag.addr !== ldpc_pkg::ADDR_W'(next_addr)) begin
					timing_errs++;
					$display("** Error res.tag.addr: got %h, expected %h", res.tag.addr, next_addr);
				end
				if (cycle - start_cycle != FIRST_ROW + next_addr) begin
					timing_errs++;
					$display("row %0d came %0d cycles after start, expected %0d",
						next_addr, cycle - start_cycle, FIRST_ROW + next_addr);
				end
				if (res.tag.last !== (next_addr == LAST_ROW)) begin
					timing_errs++;
					$display("** Error res.tag.last: got %h, expected %h",
						res.tag.last, next_addr == LAST_ROW);
				end
				if (done !== res.tag.last) begin
					timing_errs++;
					$display("** Error done: got %h, expected %h", done, res.tag.last);
				end
				if (next_addr == LAST_ROW) begin
					in_run        = 1'b0;
					busy_fall_due = 1'b1;
				end
				next_addr++;
			end
			if (start && !busy) begin // a start while busy is dropped by the DUT
				started     = 1'b1;
				in_run      = 1'b1;
				start_cycle = cycle;
				next_addr   = 0;
			end
		end
	end

endmodule

//--- tb/tb_ldpc_row_decoder.sv
`timescale 1ns/10ps

module tb_ldpc_row_decoder;

	localparam int NUM_TESTS      = 5;
	localparam int LOAD_CYCLES    = 3 * ldpc_pkg::CH_BUFF_DEPTH + 8; // three loads, reset, idle
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (ldpc_pkg::CH_BUFF_DEPTH + 12) + LOAD_CYCLES;

	logic                  read_clk;
	logic                  arst_n;
	logic                  start;
	ldpc_pkg::ch_write_t   wr;
	logic                  busy;
	logic                  done;
	ldpc_pkg::row_result_t res;
	logic [31:0]           lfsr;
	int                    cycle_count;
	int                    test_num;
	int                    pass_count;
	int                    fail_count;
	int                    errs_before;
	int                    reset_errs;
	int                    c2v_errs;
	int                    vnu_errs;
	int                    timing_errs;
	int                    rows_checked;

	ldpc_row_decoder dut_i (
		.read_clk (read_clk),
		.arst_n   (arst_n),
		.start    (start),
		.wr       (wr),
		.busy     (busy),
		.done     (done),
		.res      (res)
	);

	ldpc_scoreboard scoreboard_i (
		.read_clk     (read_clk),
		.arst_n       (arst_n),
		.start        (start),
		.busy         (busy),
		.done         (done),
		.wr           (wr),
		.res          (res),
		.reset_errs   (reset_errs),
		.c2v_errs     (c2v_errs),
		.vnu_errs     (vnu_errs),
		.timing_errs  (timing_errs),
		.rows_checked (rows_checked)
	);

	initial begin
		read_clk = 1'b0;
		forever #20 read_clk = ~read_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge read_clk);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing", cycle_count);
		$display("Done: errors found");
		$finish;
	end

	// galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic ldpc_pkg::row_msgs_t random_row();
		ldpc_pkg::row_msgs_t row;
		for (int c = 0; c < ldpc_pkg::CN_DEGREE; c++) begin
			for (int l = 0; l < ldpc_pkg::CHECK_PARALLELISM; l++) begin
				row[c][l] = ldpc_pkg::msg_t'(take_bits(ldpc_pkg::QUAN_SIZE));
			end
		end
		return row;
	endfunction

	function automatic int error_total();
		return reset_errs + c2v_errs + vnu_errs + timing_errs;
	endfunction

	task automatic load_rows(input int first, input int count, input logic en_ch,
		input logic en_c2v);
		ldpc_pkg::row_msgs_t ch_row;
		ldpc_pkg::row_msgs_t c2v_row;
		int                  a;
		for (int i = 0; i < count; i++) begin
			a       = (first + i) % ldpc_pkg::CH_BUFF_DEPTH;
			ch_row  = random_row();
			c2v_row = random_row();
			ch_row[a % ldpc_pkg::CN_DEGREE][0]        = ldpc_pkg::msg_t'(-8);
			ch_row[(a + 1) % ldpc_pkg::CN_DEGREE][1]  = '0; // zero counts as positive
			c2v_row[(a + 2) % ldpc_pkg::CN_DEGREE][0] = ldpc_pkg::msg_t'(-8);
			@(posedge read_clk);
			#2;
			wr = '{we_ch: en_ch, we_c2v: en_c2v, addr: ldpc_pkg::ADDR_W'(a),
				ch: ch_row, c2v: c2v_row};
		end
		@(posedge read_clk);
		#2;
		wr = '0;
	endtask

	task automatic pulse_start();
		@(posedge read_clk);
		#2;
		start = 1'b1;
		@(posedge read_clk);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_run_end();
		@(negedge read_clk);
		while (!done) @(negedge read_clk);
		while (busy) @(negedge read_clk);
	endtask

	task automatic report_test(input string name, input int errs);
		test_num++;
		if (errs == 0) begin
			pass_count++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			fail_count++;
			$display("test %0d %s: failed with %0d errors", test_num, name, errs);
		end
	endtask

	initial begin
		lfsr       = 32'h8c1f_a02d;
		arst_n     = 1'b0;
		start      = 1'b0;
		wr         = '0;
		test_num   = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (4) @(posedge read_clk);
		#2;
		arst_n = 1'b1;

		repeat (6) @(posedge read_clk); // no start yet, outputs stay low
		report_test("reset state", reset_errs);

		load_rows(0, ldpc_pkg::CH_BUFF_DEPTH, 1'b1, 1'b1);
		pulse_start();
		wait_run_end();
		report_test("min-sum values", c2v_errs);
		report_test("vnu values", vnu_errs);
		report_test("timing", timing_errs);

		errs_before = error_total();
		load_rows(2, 3, 1'b1, 1'b0);
		load_rows(5, 2, 1'b0, 1'b1); // wraps to row 0
		pulse_start();
		repeat (ldpc_pkg::CH_BUFF_DEPTH) @(posedge read_clk);
		pulse_start(); // lands while the last rows drain
		wait_run_end();
		load_rows(0, 2, 1'b1, 1'b1);
		pulse_start();
		wait_run_end();
		report_test("back-to-back runs", error_total() - errs_before);

		$display("summary: %0d passed, %0d failed, %0d rows checked, %0d errors",
			pass_count, fail_count, rows_checked, error_total());
		if (fail_count == 0 && error_total() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- project.f
common/ldpc_pkg.sv
rtl/ch_msg_ram.sv
rtl/chunk_counter.sv
rtl/decode_ctrl.sv
pe/cnu_min_sum.sv
pe/vnu_update.sv
rtl/ldpc_row_decoder.sv
tb/ldpc_checker.sv
tb/ldpc_scoreboard.sv
tb/tb_ldpc_row_decoder.sv
